// File: list.f
src/ext_pkg.sv
src/bus_ifs.sv
src/mem_arbiter.sv
src/slow_mem.sv
src/memcopy_dma.sv
src/reg_demux.sv
src/intr_ctrl.sv
src/power_switch_emu.sv
src/ext_subsystem_top.sv
sim/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the external subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top -f list.f -o Vtb_top

./obj_dir/Vtb_top > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
  exit 0
fi
exit 1

// File: sim/tb_top.sv
// ---------------------------------------------------------------------
// Testbench for the external subsystem
// Drives the host memory port, register bus and power switches
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import ext_pkg::*;

  localparam int CLK_HALF   = 4;
  localparam int SAMPLE_DLY = 3;
  localparam int GNT_BOUND  = 3 * (MEM_LATENCY + 1);
  // Watchdog limit is four times the sum of these per-test bounds
  localparam int T1_CYCLES  = 1000;
  localparam int T2_CYCLES  = 200;
  localparam int T3_CYCLES  = 3000;
  localparam int T4_CYCLES  = 3000;
  localparam int T5_CYCLES  = 600;
  localparam int T6_CYCLES  = 200;
  localparam int WDOG_CYCLES =
    4 * (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES + T6_CYCLES);

  logic                   clk_i;
  logic                   reset_i;
  logic                   host_req;
  logic                   host_we;
  logic [BE_W-1:0]        host_be;
  logic [ADDR_W-1:0]      host_addr;
  logic [DATA_W-1:0]      host_wdata;
  logic                   host_gnt;
  logic                   host_rvalid;
  logic [DATA_W-1:0]      host_rdata;
  logic                   reg_valid;
  logic                   reg_write;
  logic [ADDR_W-1:0]      reg_addr;
  logic [DATA_W-1:0]      reg_wdata;
  logic                   reg_ready;
  logic [DATA_W-1:0]      reg_rdata;
  logic [NUM_DOMAINS-1:0] pwr_switch_n;
  logic [NUM_DOMAINS-1:0] pwr_ack_n;
  logic [NUM_INT-1:0]     intr;

  logic [DATA_W-1:0] shadow [MEM_WORDS];
  int seed = 13244;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int run_cycles = 0;

  ext_subsystem_top ext_subsystem_top_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .host_req_i     (host_req),
    .host_we_i      (host_we),
    .host_be_i      (host_be),
    .host_addr_i    (host_addr),
    .host_wdata_i   (host_wdata),
    .host_gnt_o     (host_gnt),
    .host_rvalid_o  (host_rvalid),
    .host_rdata_o   (host_rdata),
    .reg_valid_i    (reg_valid),
    .reg_write_i    (reg_write),
    .reg_addr_i     (reg_addr),
    .reg_wdata_i    (reg_wdata),
    .reg_ready_o    (reg_ready),
    .reg_rdata_o    (reg_rdata),
    .pwr_switch_n_i (pwr_switch_n),
    .pwr_ack_n_o    (pwr_ack_n),
    .intr_o         (intr)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      run_cycles <= 0;
    end else if (run_cycles < 100000) begin
      run_cycles <= run_cycles + 1;
    end
  end

  // ------------------------------------------------------------------
  // Reporting helpers
  // ------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("Error: %s", what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errs_before);
    end else begin
      $display("Test %s: ok", name);
    end
  endtask

  // ------------------------------------------------------------------
  // Concurrent checks
  // ------------------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (reset_i) reg_valid |-> reg_ready)
    else report_problem("reg_ready_o low while reg_valid_i high");

  assert property (@(posedge clk_i) disable iff (reset_i)
                   $past(host_gnt, MEM_LATENCY) |-> host_rvalid)
    else report_problem("host_rvalid_o missing after host grant");

  assert property (@(posedge clk_i) disable iff (reset_i)
                   host_rvalid |-> $past(host_gnt, MEM_LATENCY))
    else report_problem("host_rvalid_o without host grant");

  assert property (@(posedge clk_i) disable iff (reset_i || run_cycles <= SWITCH_ACK_LATENCY)
                   pwr_ack_n == $past(pwr_switch_n, SWITCH_ACK_LATENCY))
    else report_mismatch("pwr_ack_n_o", 32'($sampled(pwr_ack_n)),
                         32'($past(pwr_switch_n, SWITCH_ACK_LATENCY)));

  // ------------------------------------------------------------------
  // Stimulus tasks drive inputs on the falling edge
  // ------------------------------------------------------------------
  task automatic next_sample();
    @(negedge clk_i);
    #SAMPLE_DLY;
  endtask

  function automatic logic [MEM_IDX_W-1:0] word_idx(input logic [ADDR_W-1:0] a);
    return a[MEM_IDX_W+1:2];
  endfunction

  task automatic mem_access(input logic we, input logic [BE_W-1:0] be,
                            input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata);
    int waited;
    @(negedge clk_i);
    host_req   = 1'b1;
    host_we    = we;
    host_be    = be;
    host_addr  = addr;
    host_wdata = wdata;
    waited     = 0;
    #SAMPLE_DLY;
    while (!host_gnt && waited <= GNT_BOUND) begin
      next_sample();
      waited++;
    end
    assert (waited <= GNT_BOUND)
      else report_problem("host request not granted in time");
    @(negedge clk_i);
    host_req = 1'b0;
    waited   = 0;
    #SAMPLE_DLY;
    while (!host_rvalid && waited <= MEM_LATENCY) begin
      next_sample();
      waited++;
    end
    rdata = host_rdata;
  endtask

  task automatic mem_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] unused;
    mem_access(1'b1, be, addr, data, unused);
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        shadow[word_idx(addr)][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic mem_read_check(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] got;
    logic [DATA_W-1:0] exp;
    mem_access(1'b0, '1, addr, '0, got);
    exp = shadow[word_idx(addr)];
    assert (got === exp) else report_mismatch("host_rdata_o", got, exp);
  endtask

  task automatic reg_access(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    @(negedge clk_i);
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    #SAMPLE_DLY;
    rdata = reg_rdata;
    @(negedge clk_i);
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic reg_write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] got;
    reg_access(1'b0, addr, '0, got);
    assert (got === exp) else report_mismatch("reg_rdata_o", got, exp);
  endtask

  task automatic fill_random(input int first, input int count);
    logic [DATA_W-1:0] r;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      mem_write(ADDR_W'((first + i) * 4), r, '1);
    end
  endtask

  task automatic check_region(input int first, input int count);
    for (int i = 0; i < count; i++) begin
      mem_read_check(ADDR_W'((first + i) * 4));
    end
  endtask

  task automatic start_copy(input int src_w, input int dst_w, input int len);
    reg_write_word(MEMCOPY_BASE + REG_SRC, ADDR_W'(src_w * 4));
    reg_write_word(MEMCOPY_BASE + REG_DST, ADDR_W'(dst_w * 4));
    reg_write_word(MEMCOPY_BASE + REG_LEN, DATA_W'(len));
    reg_write_word(MEMCOPY_BASE + REG_CTRL, 32'h1);
    // Expected memory after the copy
    for (int i = 0; i < len; i++) begin
      shadow[(dst_w + i) % MEM_WORDS] = shadow[(src_w + i) % MEM_WORDS];
    end
  endtask

  task automatic wait_copy_idle(input int bound);
    logic [DATA_W-1:0] ctrl;
    int polls;
    polls = 0;
    ctrl  = 32'h1;
    while (ctrl[0] && polls < bound) begin
      reg_access(1'b0, MEMCOPY_BASE + REG_CTRL, '0, ctrl);
      polls++;
    end
    assert (!ctrl[0]) else report_problem("copy engine stayed busy");
  endtask

  // ------------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------------
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: run exceeded %0d cycles", WDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    int e;
    int len;
    logic [DATA_W-1:0] r;
    logic [DATA_W-1:0] a;

    reset_i = 1'b1;
    host_req = 1'b0;
    host_we = 1'b0;
    host_be = '0;
    host_addr = '0;
    host_wdata = '0;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    pwr_switch_n = '1;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;

    // Host writes with random byte enables, then reads
    e = errors;
    #SAMPLE_DLY;
    assert (host_gnt === 1'b0) else report_mismatch("host_gnt_o", 32'(host_gnt), 0);
    assert (host_rvalid === 1'b0) else report_mismatch("host_rvalid_o", 32'(host_rvalid), 0);
    assert (intr === '0) else report_mismatch("intr_o", 32'(intr), 0);
    assert (pwr_ack_n === '1) else report_mismatch("pwr_ack_n_o", 32'(pwr_ack_n), 32'h7);
    fill_random(0, 16);
    for (int i = 0; i < 32; i++) begin
      r = $random(seed);
      a = $random(seed);
      mem_write(ADDR_W'(a[3:0]) * 4, r, a[7:4]);
    end
    check_region(0, 16);
    finish_test("host_memory", e);

    // Register readback and unmapped addresses
    e = errors;
    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      reg_write_word(MEMCOPY_BASE + ADDR_W'(4 * i), r);
      reg_read_check(MEMCOPY_BASE + ADDR_W'(4 * i), r);
    end
    reg_read_check(32'h0000_0200, REG_ERR_DATA);
    reg_read_check(32'h0001_0004, REG_ERR_DATA);
    reg_read_check(32'hFFFF_FF00, REG_ERR_DATA);
    finish_test("register_map", e);

    // Copy of random length with guard words, then an empty copy
    e = errors;
    a = $random(seed);
    len = 1 + int'(a[4:0]);
    fill_random(256, len);
    fill_random(511, 1);
    fill_random(512 + len, 1);
    start_copy(256, 512, len);
    wait_copy_idle(T3_CYCLES / 4);
    check_region(511, len + 2);
    start_copy(511, 512 + len, 0);
    wait_copy_idle(8);
    check_region(511, len + 2);
    finish_test("memcopy", e);

    // Host traffic in a separate region while a copy runs
    e = errors;
    fill_random(320, 32);
    start_copy(320, 640, 32);
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      mem_write(ADDR_W'((800 + i) * 4), r, '1);
      mem_read_check(ADDR_W'((800 + i) * 4));
    end
    wait_copy_idle(T4_CYCLES / 4);
    check_region(640, 32);
    check_region(800, 16);
    finish_test("concurrent_host", e);

    // Copy-done interrupt with and without enable
    e = errors;
    reg_write_word(INTR_BASE + REG_STATUS, 32'h3);
    reg_write_word(INTR_BASE + REG_ENABLE, 32'(1 << INT_MEMCOPY));
    start_copy(256, 700, 4);
    wait_copy_idle(200);
    next_sample();
    assert (intr[INT_MEMCOPY] === 1'b1)
      else report_mismatch("intr_o", 32'(intr), 32'(1 << INT_MEMCOPY));
    reg_write_word(INTR_BASE + REG_STATUS, 32'(1 << INT_MEMCOPY));
    #SAMPLE_DLY;
    assert (intr === '0) else report_mismatch("intr_o", 32'(intr), 0);
    reg_write_word(INTR_BASE + REG_ENABLE, 32'h0);
    start_copy(256, 700, 0);
    next_sample();
    reg_read_check(INTR_BASE + REG_STATUS, 32'(1 << INT_MEMCOPY));
    assert (intr === '0) else report_mismatch("intr_o", 32'(intr), 0);
    finish_test("interrupts", e);

    // Power switch acknowledge delay and its interrupt
    e = errors;
    reg_write_word(INTR_BASE + REG_STATUS, 32'h3);
    reg_write_word(INTR_BASE + REG_ENABLE, 32'(1 << INT_PWR_ACK));
    @(negedge clk_i);
    pwr_switch_n = 3'b110;
    for (int i = 0; i < 40; i++) begin
      @(negedge clk_i);
      r = $random(seed);
      pwr_switch_n = r[NUM_DOMAINS-1:0];
    end
    repeat (SWITCH_ACK_LATENCY + 2) @(negedge clk_i);
    #SAMPLE_DLY;
    assert (pwr_ack_n === pwr_switch_n)
      else report_mismatch("pwr_ack_n_o", 32'(pwr_ack_n), 32'(pwr_switch_n));
    assert (intr[INT_PWR_ACK] === 1'b1)
      else report_mismatch("intr_o", 32'(intr), 32'(1 << INT_PWR_ACK));
    finish_test("power_switch", e);

    $display("Tests run %0d, tests failed %0d, check failures %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/bus_ifs.sv
// ---------------------------------------------------------------------
// Memory bus (req/gnt/rvalid) and register bus (valid/ready)
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
  import ext_pkg::*;

  logic              req;
  logic              we;
  logic [BE_W-1:0]   be;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              gnt;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;

  modport manager (output req, we, be, addr, wdata, input gnt, rvalid, rdata);
  modport subordinate (input req, we, be, addr, wdata, output gnt, rvalid, rdata);
endinterface

interface reg_bus_if;
  import ext_pkg::*;

  logic              valid;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              ready;
  logic [DATA_W-1:0] rdata;

  modport host (output valid, write, addr, wdata, input ready, rdata);
  modport device (input valid, write, addr, wdata, output ready, rdata);
endinterface

`default_nettype wire

// File: src/ext_pkg.sv
// ---------------------------------------------------------------------
// External subsystem package
// Bus widths, memory geometry, latencies and the register map
// ---------------------------------------------------------------------
`default_nettype none

package ext_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // Slow memory, word index from address bits 11:2
  localparam int MEM_WORDS   = 1024;
  localparam int MEM_IDX_W   = 10;
  localparam int MEM_LATENCY = 2;

  // Memory managers
  localparam int NUM_MGR    = 3;
  localparam int MGR_HOST   = 0;
  localparam int MGR_DMA_RD = 1;
  localparam int MGR_DMA_WR = 2;

  // Power domains
  localparam int NUM_DOMAINS        = 3;
  localparam int SWITCH_ACK_LATENCY = 16;

  // Interrupt lines
  localparam int NUM_INT     = 2;
  localparam int INT_MEMCOPY = 0;
  localparam int INT_PWR_ACK = 1;

  // ------------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------------
  localparam int REG_TGT_W = 1;

  localparam logic [ADDR_W-1:0] MEMCOPY_BASE   = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] INTR_BASE      = 32'h0000_0100;
  localparam logic [ADDR_W-1:0] REG_BLOCK_SPAN = 32'h0000_0100;

  // Memcopy block offsets
  localparam logic [ADDR_W-1:0] REG_SRC  = 32'h0;
  localparam logic [ADDR_W-1:0] REG_DST  = 32'h4;
  localparam logic [ADDR_W-1:0] REG_LEN  = 32'h8;
  localparam logic [ADDR_W-1:0] REG_CTRL = 32'hC;

  // Interrupt block offsets
  localparam logic [ADDR_W-1:0] REG_STATUS = 32'h0;
  localparam logic [ADDR_W-1:0] REG_ENABLE = 32'h4;

  localparam logic [DATA_W-1:0] REG_ERR_DATA = 32'hBADC_AB1E;

endpackage

`default_nettype wire

// File: src/ext_subsystem_top.sv
// ---------------------------------------------------------------------
// External subsystem top, memory, copy engine, register blocks,
// interrupt collector and power switch acknowledge emulation
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ext_subsystem_top (
  input  wire                                clk_i,
  input  wire                                reset_i,
  // Host memory port
  input  wire                                host_req_i,
  input  wire                                host_we_i,
  input  wire  [ext_pkg::BE_W-1:0]           host_be_i,
  input  wire  [ext_pkg::ADDR_W-1:0]         host_addr_i,
  input  wire  [ext_pkg::DATA_W-1:0]         host_wdata_i,
  output logic                               host_gnt_o,
  output logic                               host_rvalid_o,
  output logic [ext_pkg::DATA_W-1:0]         host_rdata_o,
  // Register port
  input  wire                                reg_valid_i,
  input  wire                                reg_write_i,
  input  wire  [ext_pkg::ADDR_W-1:0]         reg_addr_i,
  input  wire  [ext_pkg::DATA_W-1:0]         reg_wdata_i,
  output logic                               reg_ready_o,
  output logic [ext_pkg::DATA_W-1:0]         reg_rdata_o,
  // Power switches
  input  wire  [ext_pkg::NUM_DOMAINS-1:0]    pwr_switch_n_i,
  output logic [ext_pkg::NUM_DOMAINS-1:0]    pwr_ack_n_o,
  output logic [ext_pkg::NUM_INT-1:0]        intr_o
);

  mem_bus_if host_bus ();
  mem_bus_if dma_rd_bus ();
  mem_bus_if dma_wr_bus ();
  mem_bus_if mem_bus ();
  reg_bus_if reg_host ();
  reg_bus_if reg_memcopy ();
  reg_bus_if reg_intr ();

  logic memcopy_done;
  logic pwr_ack_event;

  // Plain ports onto the bus interfaces
  assign host_bus.req   = host_req_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.be    = host_be_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_wdata_i;
  assign host_gnt_o     = host_bus.gnt;
  assign host_rvalid_o  = host_bus.rvalid;
  assign host_rdata_o   = host_bus.rdata;

  assign reg_host.valid = reg_valid_i;
  assign reg_host.write = reg_write_i;
  assign reg_host.addr  = reg_addr_i;
  assign reg_host.wdata = reg_wdata_i;
  assign reg_ready_o    = reg_host.ready;
  assign reg_rdata_o    = reg_host.rdata;

  mem_arbiter mem_arbiter_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .mgr_host   (host_bus),
    .mgr_dma_rd (dma_rd_bus),
    .mgr_dma_wr (dma_wr_bus),
    .mem        (mem_bus)
  );

  slow_mem slow_mem_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (mem_bus)
  );

  memcopy_dma memcopy_dma_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .regs    (reg_memcopy),
    .rd      (dma_rd_bus),
    .wr      (dma_wr_bus),
    .done_o  (memcopy_done)
  );

  reg_demux reg_demux_inst (
    .host    (reg_host),
    .memcopy (reg_memcopy),
    .intr    (reg_intr)
  );

  intr_ctrl intr_ctrl_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .regs            (reg_intr),
    .memcopy_done_i  (memcopy_done),
    .pwr_ack_event_i (pwr_ack_event),
    .intr_o          (intr_o)
  );

  power_switch_emu power_switch_emu_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .switch_n_i  (pwr_switch_n_i),
    .ack_n_o     (pwr_ack_n_o),
    .ack_event_o (pwr_ack_event)
  );

endmodule

`default_nettype wire

// File: src/intr_ctrl.sv
// ---------------------------------------------------------------------
// Interrupt collector, sticky status and enable mask
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module intr_ctrl (
  input  wire                           clk_i,
  input  wire                           reset_i,
  reg_bus_if.device                     regs,
  input  wire                           memcopy_done_i,
  input  wire                           pwr_ack_event_i,
  output logic [ext_pkg::NUM_INT-1:0]   intr_o
);
  import ext_pkg::*;

  logic [NUM_INT-1:0] status_q;
  logic [NUM_INT-1:0] enable_q;
  logic [NUM_INT-1:0] event_v;
  logic [NUM_INT-1:0] clear_v;
  logic               reg_wr;

  always_comb begin
    event_v              = '0;
    event_v[INT_MEMCOPY] = memcopy_done_i;
    event_v[INT_PWR_ACK] = pwr_ack_event_i;
  end

  assign reg_wr  = regs.valid && regs.write;
  assign clear_v = (reg_wr && regs.addr == REG_STATUS) ? regs.wdata[NUM_INT-1:0] : '0;

  // Event beats clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      status_q <= '0;
      enable_q <= '0;
    end else begin
      status_q <= (status_q & ~clear_v) | event_v;
      if (reg_wr && regs.addr == REG_ENABLE) begin
        enable_q <= regs.wdata[NUM_INT-1:0];
      end
    end
  end

  assign intr_o     = status_q & enable_q;
  assign regs.ready = regs.valid;

  always_comb begin
    case (regs.addr)
      REG_STATUS: regs.rdata = DATA_W'(status_q);
      REG_ENABLE: regs.rdata = DATA_W'(enable_q);
      default:    regs.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
// ---------------------------------------------------------------------
// Round-robin arbiter, three memory managers onto one memory
// Tracks the owner of the accepted access for response routing
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input wire              clk_i,
  input wire              reset_i,
  mem_bus_if.subordinate  mgr_host,
  mem_bus_if.subordinate  mgr_dma_rd,
  mem_bus_if.subordinate  mgr_dma_wr,
  mem_bus_if.manager      mem
);
  import ext_pkg::*;

  typedef logic [$clog2(NUM_MGR)-1:0] mgr_idx_t;

  logic [NUM_MGR-1:0] req_v;
  logic [NUM_MGR-1:0] we_v;
  logic [BE_W-1:0]    be_v    [NUM_MGR];
  logic [ADDR_W-1:0]  addr_v  [NUM_MGR];
  logic [DATA_W-1:0]  wdata_v [NUM_MGR];
  mgr_idx_t           owner_q;
  mgr_idx_t           sel;
  mgr_idx_t           cand;
  logic               found;

  // Gather manager requests
  assign req_v[MGR_HOST]     = mgr_host.req;
  assign we_v[MGR_HOST]      = mgr_host.we;
  assign be_v[MGR_HOST]      = mgr_host.be;
  assign addr_v[MGR_HOST]    = mgr_host.addr;
  assign wdata_v[MGR_HOST]   = mgr_host.wdata;
  assign req_v[MGR_DMA_RD]   = mgr_dma_rd.req;
  assign we_v[MGR_DMA_RD]    = mgr_dma_rd.we;
  assign be_v[MGR_DMA_RD]    = mgr_dma_rd.be;
  assign addr_v[MGR_DMA_RD]  = mgr_dma_rd.addr;
  assign wdata_v[MGR_DMA_RD] = mgr_dma_rd.wdata;
  assign req_v[MGR_DMA_WR]   = mgr_dma_wr.req;
  assign we_v[MGR_DMA_WR]    = mgr_dma_wr.we;
  assign be_v[MGR_DMA_WR]    = mgr_dma_wr.be;
  assign addr_v[MGR_DMA_WR]  = mgr_dma_wr.addr;
  assign wdata_v[MGR_DMA_WR] = mgr_dma_wr.wdata;

  // Search starts just after the last granted manager
  always_comb begin
    sel   = owner_q;
    cand  = owner_q;
    found = 1'b0;
    for (int k = 1; k <= NUM_MGR; k++) begin
      cand = mgr_idx_t'((int'(owner_q) + k) % NUM_MGR);
      if (!found && req_v[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
  end

  assign mem.req   = |req_v;
  assign mem.we    = we_v[sel];
  assign mem.be    = be_v[sel];
  assign mem.addr  = addr_v[sel];
  assign mem.wdata = wdata_v[sel];

  // Owner doubles as the round-robin pointer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner_q <= mgr_idx_t'(MGR_DMA_WR);
    end else if (mem.gnt) begin
      owner_q <= sel;
    end
  end

  assign mgr_host.gnt      = mem.gnt && (sel == mgr_idx_t'(MGR_HOST));
  assign mgr_dma_rd.gnt    = mem.gnt && (sel == mgr_idx_t'(MGR_DMA_RD));
  assign mgr_dma_wr.gnt    = mem.gnt && (sel == mgr_idx_t'(MGR_DMA_WR));
  assign mgr_host.rvalid   = mem.rvalid && (owner_q == mgr_idx_t'(MGR_HOST));
  assign mgr_dma_rd.rvalid = mem.rvalid && (owner_q == mgr_idx_t'(MGR_DMA_RD));
  assign mgr_dma_wr.rvalid = mem.rvalid && (owner_q == mgr_idx_t'(MGR_DMA_WR));
  assign mgr_host.rdata    = (owner_q == mgr_idx_t'(MGR_HOST)) ? mem.rdata : '0;
  assign mgr_dma_rd.rdata  = (owner_q == mgr_idx_t'(MGR_DMA_RD)) ? mem.rdata : '0;
  assign mgr_dma_wr.rdata  = (owner_q == mgr_idx_t'(MGR_DMA_WR)) ? mem.rdata : '0;

endmodule

`default_nettype wire

// File: src/memcopy_dma.sv
// ---------------------------------------------------------------------
// Memcopy engine, register programmed, one word read then written
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module memcopy_dma (
  input  wire         clk_i,
  input  wire         reset_i,
  reg_bus_if.device   regs,
  mem_bus_if.manager  rd,
  mem_bus_if.manager  wr,
  output logic        done_o
);
  import ext_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_WR_REQ,
    ST_WR_WAIT
  } state_t;

  state_t            state_q;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [DATA_W-1:0] len_q;
  logic [ADDR_W-1:0] cur_src_q;
  logic [ADDR_W-1:0] cur_dst_q;
  logic [DATA_W-1:0] remain_q;
  logic [DATA_W-1:0] word_q;
  logic              busy;
  logic              reg_wr;
  logic              start;

  assign busy   = (state_q != ST_IDLE);
  assign reg_wr = regs.valid && regs.write;
  assign start  = reg_wr && (regs.addr == REG_CTRL) && regs.wdata[0] && !busy;

  // ------------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------------
  assign regs.ready = regs.valid;

  always_comb begin
    case (regs.addr)
      REG_SRC:  regs.rdata = src_q;
      REG_DST:  regs.rdata = dst_q;
      REG_LEN:  regs.rdata = len_q;
      REG_CTRL: regs.rdata = {{(DATA_W-1){1'b0}}, busy};
      default:  regs.rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (reg_wr) begin
      if (regs.addr == REG_SRC) src_q <= regs.wdata;
      if (regs.addr == REG_DST) dst_q <= regs.wdata;
      if (regs.addr == REG_LEN) len_q <= regs.wdata;
    end
  end

  // ------------------------------------------------------------------
  // Copy FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start && len_q == '0) begin
            done_o <= 1'b1;
          end else if (start) begin
            state_q <= ST_RD_REQ;
          end
        end
        ST_RD_REQ:  if (rd.gnt) state_q <= ST_RD_WAIT;
        ST_RD_WAIT: if (rd.rvalid) state_q <= ST_WR_REQ;
        ST_WR_REQ:  if (wr.gnt) state_q <= ST_WR_WAIT;
        ST_WR_WAIT: begin
          if (wr.rvalid) begin
            // Last word written
            if (remain_q == DATA_W'(1)) begin
              state_q <= ST_IDLE;
              done_o  <= 1'b1;
            end else begin
              state_q <= ST_RD_REQ;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Working pointers and the word in flight
  always_ff @(posedge clk_i) begin
    if (start) begin
      cur_src_q <= src_q;
      cur_dst_q <= dst_q;
      remain_q  <= len_q;
    end else if (state_q == ST_WR_WAIT && wr.rvalid) begin
      cur_src_q <= cur_src_q + ADDR_W'(4);
      cur_dst_q <= cur_dst_q + ADDR_W'(4);
      remain_q  <= remain_q - DATA_W'(1);
    end
    if (state_q == ST_RD_WAIT && rd.rvalid) begin
      word_q <= rd.rdata;
    end
  end

  assign rd.req   = (state_q == ST_RD_REQ);
  assign rd.we    = 1'b0;
  assign rd.be    = '1;
  assign rd.addr  = cur_src_q;
  assign rd.wdata = '0;

  assign wr.req   = (state_q == ST_WR_REQ);
  assign wr.we    = 1'b1;
  assign wr.be    = '1;
  assign wr.addr  = cur_dst_q;
  assign wr.wdata = word_q;

endmodule

`default_nettype wire

// File: src/power_switch_emu.sv
// ---------------------------------------------------------------------
// Power switch acknowledge emulation, fixed delay per domain
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module power_switch_emu (
  input  wire                                clk_i,
  input  wire                                reset_i,
  input  wire  [ext_pkg::NUM_DOMAINS-1:0]    switch_n_i,
  output logic [ext_pkg::NUM_DOMAINS-1:0]    ack_n_o,
  output logic                               ack_event_o
);
  import ext_pkg::*;

  // One extra stage keeps the previous acknowledge for edge detection
  logic [NUM_DOMAINS-1:0] stage_q [SWITCH_ACK_LATENCY + 1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i <= SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i <= SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign ack_n_o     = stage_q[SWITCH_ACK_LATENCY-1];
  assign ack_event_o = |(stage_q[SWITCH_ACK_LATENCY] ^ stage_q[SWITCH_ACK_LATENCY-1]);

endmodule

`default_nettype wire

// File: src/reg_demux.sv
// ---------------------------------------------------------------------
// Register bus decoder, two register blocks plus error reply
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_demux (
  reg_bus_if.device  host,
  reg_bus_if.host    memcopy,
  reg_bus_if.host    intr
);
  import ext_pkg::*;

  logic [ADDR_W-1:0]    mc_off;
  logic [ADDR_W-1:0]    in_off;
  logic                 hit_mc;
  logic                 hit_in;
  logic                 mapped;
  logic [REG_TGT_W-1:0] tgt;

  // Offsets wrap below the base, so one compare covers both bounds
  assign mc_off = host.addr - MEMCOPY_BASE;
  assign in_off = host.addr - INTR_BASE;
  assign hit_mc = (mc_off < REG_BLOCK_SPAN);
  assign hit_in = (in_off < REG_BLOCK_SPAN);
  assign mapped = hit_mc || hit_in;
  assign tgt    = REG_TGT_W'(hit_in);

  assign memcopy.valid = host.valid && mapped && (tgt == '0);
  assign memcopy.write = host.write;
  assign memcopy.addr  = mc_off;
  assign memcopy.wdata = host.wdata;

  assign intr.valid = host.valid && mapped && (tgt != '0);
  assign intr.write = host.write;
  assign intr.addr  = in_off;
  assign intr.wdata = host.wdata;

  // Response mux
  always_comb begin
    if (!mapped) begin
      host.ready = host.valid;
      host.rdata = REG_ERR_DATA;
    end else if (tgt == '0) begin
      host.ready = memcopy.ready;
      host.rdata = memcopy.rdata;
    end else begin
      host.ready = intr.ready;
      host.rdata = intr.rdata;
    end
  end

endmodule

`default_nettype wire

// File: src/slow_mem.sv
// ---------------------------------------------------------------------
// Slow word memory, byte enables, fixed response latency
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slow_mem (
  input wire              clk_i,
  input wire              reset_i,
  mem_bus_if.subordinate  bus
);
  import ext_pkg::*;

  typedef logic [$clog2(MEM_LATENCY + 1)-1:0] cnt_t;

  logic [DATA_W-1:0]    mem_q [MEM_WORDS];
  logic [DATA_W-1:0]    rdata_q;
  logic [MEM_IDX_W-1:0] idx;
  cnt_t                 cnt_q;

  assign idx     = bus.addr[MEM_IDX_W+1:2];
  assign bus.gnt = bus.req && (cnt_q == '0);

  // Countdown from grant to response, one access at a time
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (bus.gnt) begin
      cnt_q <= cnt_t'(MEM_LATENCY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - cnt_t'(1);
    end
  end

  assign bus.rvalid = (cnt_q == cnt_t'(1));

  // Storage access at the grant
  always_ff @(posedge clk_i) begin
    if (bus.gnt) begin
      if (bus.we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (bus.be[b]) begin
            mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire
